// File: cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            cmd_valid,
    input  logic                            cmd_op,
    input  logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   cmd_wdata,
    output logic                            cmd_credit,
    output logic                            q_valid,
    output logic                            q_op,
    output logic [eeprom_pkg::ADDR_W-1:0]   q_addr,
    output logic [eeprom_pkg::DATA_W-1:0]   q_wdata,
    input  logic                            q_pop
);

    logic                            op_mem   [eeprom_pkg::CMD_DEPTH];
    logic [eeprom_pkg::ADDR_W-1:0]   addr_mem [eeprom_pkg::CMD_DEPTH];
    logic [eeprom_pkg::DATA_W-1:0]   data_mem [eeprom_pkg::CMD_DEPTH];
    logic [eeprom_pkg::QPTR_W-1:0]   wr_ptr;
    logic [eeprom_pkg::QPTR_W-1:0]   rd_ptr;
    logic [eeprom_pkg::CREDIT_W-1:0] count;

    function automatic logic [eeprom_pkg::QPTR_W-1:0] ptr_inc(
        input logic [eeprom_pkg::QPTR_W-1:0] p
    );
        return (int'(p) == eeprom_pkg::CMD_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign q_valid = (count != '0);
    assign q_op    = op_mem[rd_ptr];
    assign q_addr  = addr_mem[rd_ptr];
    assign q_wdata = data_mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            op_mem[wr_ptr]   <= cmd_op;
            addr_mem[wr_ptr] <= cmd_addr;
            data_mem[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            cmd_credit <= q_pop;   // one credit back per entry taken
            if (cmd_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (q_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // host pushed without holding a credit
    a_no_push_full: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (int'(count) < eeprom_pkg::CMD_DEPTH))
        else $error("cmd_queue: push into full queue");

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET)
        q_pop |-> q_valid)
        else $error("cmd_queue: pop from empty queue");

endmodule

`default_nettype wire

// File: eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            cmd_valid,
    input  logic                            cmd_op,
    input  logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   cmd_wdata,
    output logic                            cmd_credit,
    output logic                            rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                            rsp_nack,
    output logic                            scl,
    output logic                            sda_pull_low,
    input  logic                            sda_in
);

    logic                            q_valid;
    logic                            q_op;
    logic [eeprom_pkg::ADDR_W-1:0]   q_addr;
    logic [eeprom_pkg::DATA_W-1:0]   q_wdata;
    logic                            q_pop;
    logic                            bit_go;
    logic [1:0]                      bit_op;
    logic [eeprom_pkg::DATA_W-1:0]   bit_wbyte;
    logic                            bit_done;
    logic [eeprom_pkg::DATA_W-1:0]   bit_rbyte;
    logic                            bit_nack;

    cmd_queue i_cmd_queue (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_credit (cmd_credit),
        .q_valid    (q_valid),
        .q_op       (q_op),
        .q_addr     (q_addr),
        .q_wdata    (q_wdata),
        .q_pop      (q_pop)
    );

    eeprom_sequencer i_eeprom_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .q_pop     (q_pop),
        .bit_go    (bit_go),
        .bit_op    (bit_op),
        .bit_wbyte (bit_wbyte),
        .bit_done  (bit_done),
        .bit_rbyte (bit_rbyte),
        .bit_nack  (bit_nack),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack)
    );

    i2c_bit_engine i_i2c_bit_engine (
        .CLK          (CLK),
        .RESET        (RESET),
        .bit_go       (bit_go),
        .bit_op       (bit_op),
        .bit_wbyte    (bit_wbyte),
        .bit_done     (bit_done),
        .bit_rbyte    (bit_rbyte),
        .bit_nack     (bit_nack),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

`default_nettype wire

// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W    = 11;   // 2 KB device
    localparam int DATA_W    = 8;
    localparam int CMD_DEPTH = 4;    // host starts with this many credits
    localparam int CREDIT_W  = $clog2(CMD_DEPTH + 1);
    localparam int QPTR_W    = $clog2(CMD_DEPTH);

    // one bus bit is four quarters
    localparam int QUARTER_CYCLES = 2;
    localparam int QCNT_W         = $clog2(QUARTER_CYCLES);

    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam logic OP_WRITE = 1'b0;
    localparam logic OP_READ  = 1'b1;

    localparam logic [1:0] BIT_OP_START  = 2'd0;
    localparam logic [1:0] BIT_OP_STOP   = 2'd1;
    localparam logic [1:0] BIT_OP_WRBYTE = 2'd2;
    localparam logic [1:0] BIT_OP_RDBYTE = 2'd3;

    // sequencer states
    localparam int SEQ_W = 4;
    localparam logic [SEQ_W-1:0] SEQ_IDLE   = 4'd0;
    localparam logic [SEQ_W-1:0] SEQ_LOAD   = 4'd1;
    localparam logic [SEQ_W-1:0] SEQ_START  = 4'd2;
    localparam logic [SEQ_W-1:0] SEQ_SEL_W  = 4'd3;
    localparam logic [SEQ_W-1:0] SEQ_ADDR   = 4'd4;
    localparam logic [SEQ_W-1:0] SEQ_DATA   = 4'd5;
    localparam logic [SEQ_W-1:0] SEQ_RSTART = 4'd6;
    localparam logic [SEQ_W-1:0] SEQ_SEL_R  = 4'd7;
    localparam logic [SEQ_W-1:0] SEQ_RDATA  = 4'd8;
    localparam logic [SEQ_W-1:0] SEQ_STOP   = 4'd9;

endpackage

`default_nettype wire

// File: eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            q_valid,
    input  logic                            q_op,
    input  logic [eeprom_pkg::ADDR_W-1:0]   q_addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   q_wdata,
    output logic                            q_pop,
    output logic                            bit_go,
    output logic [1:0]                      bit_op,
    output logic [eeprom_pkg::DATA_W-1:0]   bit_wbyte,
    input  logic                            bit_done,
    input  logic [eeprom_pkg::DATA_W-1:0]   bit_rbyte,
    input  logic                            bit_nack,
    output logic                            rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                            rsp_nack
);

    logic [eeprom_pkg::SEQ_W-1:0]    state;
    logic                            lat_op;
    logic [eeprom_pkg::ADDR_W-1:0]   lat_addr;
    logic [eeprom_pkg::DATA_W-1:0]   lat_wdata;

    // device select, high address bits ride here
    function automatic logic [eeprom_pkg::DATA_W-1:0] sel_byte(input logic rd);
        return {eeprom_pkg::DEV_CODE, lat_addr[eeprom_pkg::ADDR_W-1:8], rd};
    endfunction

    task automatic issue(input logic [1:0] op, input logic [eeprom_pkg::DATA_W-1:0] wbyte);
        bit_go    <= 1'b1;
        bit_op    <= op;
        bit_wbyte <= wbyte;
    endtask

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::SEQ_IDLE;
            q_pop     <= 1'b0;
            bit_go    <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_nack  <= 1'b0;
        end
        else
        begin
            q_pop     <= 1'b0;
            bit_go    <= 1'b0;
            rsp_valid <= 1'b0;
            case (state)
                eeprom_pkg::SEQ_IDLE:
                    if (q_valid)
                    begin
                        q_pop <= 1'b1;   // entry leaves at the end of LOAD
                        state <= eeprom_pkg::SEQ_LOAD;
                    end
                eeprom_pkg::SEQ_LOAD:
                begin
                    lat_op    <= q_op;
                    lat_addr  <= q_addr;
                    lat_wdata <= q_wdata;
                    rsp_rdata <= '0;
                    rsp_nack  <= 1'b0;
                    issue(eeprom_pkg::BIT_OP_START, '0);
                    state <= eeprom_pkg::SEQ_START;
                end
                eeprom_pkg::SEQ_START:
                    if (bit_done)
                    begin
                        issue(eeprom_pkg::BIT_OP_WRBYTE, sel_byte(1'b0));
                        state <= eeprom_pkg::SEQ_SEL_W;
                    end
                eeprom_pkg::SEQ_SEL_W, eeprom_pkg::SEQ_ADDR, eeprom_pkg::SEQ_SEL_R:
                    if (bit_done && bit_nack)   // no ack, abandon the command
                    begin
                        rsp_nack <= 1'b1;
                        issue(eeprom_pkg::BIT_OP_STOP, '0);
                        state <= eeprom_pkg::SEQ_STOP;
                    end
                    else if (bit_done && state == eeprom_pkg::SEQ_SEL_W)
                    begin
                        issue(eeprom_pkg::BIT_OP_WRBYTE, lat_addr[7:0]);
                        state <= eeprom_pkg::SEQ_ADDR;
                    end
                    else if (bit_done && state == eeprom_pkg::SEQ_SEL_R)
                    begin
                        issue(eeprom_pkg::BIT_OP_RDBYTE, '0);
                        state <= eeprom_pkg::SEQ_RDATA;
                    end
                    else if (bit_done && lat_op == eeprom_pkg::OP_READ)
                    begin
                        issue(eeprom_pkg::BIT_OP_START, '0);   // repeated start
                        state <= eeprom_pkg::SEQ_RSTART;
                    end
                    else if (bit_done)
                    begin
                        issue(eeprom_pkg::BIT_OP_WRBYTE, lat_wdata);
                        state <= eeprom_pkg::SEQ_DATA;
                    end
                eeprom_pkg::SEQ_DATA:
                    if (bit_done)
                    begin
                        rsp_nack <= bit_nack;
                        issue(eeprom_pkg::BIT_OP_STOP, '0);
                        state <= eeprom_pkg::SEQ_STOP;
                    end
                eeprom_pkg::SEQ_RSTART:
                    if (bit_done)
                    begin
                        issue(eeprom_pkg::BIT_OP_WRBYTE, sel_byte(1'b1));
                        state <= eeprom_pkg::SEQ_SEL_R;
                    end
                eeprom_pkg::SEQ_RDATA:
                    if (bit_done)
                    begin
                        rsp_rdata <= bit_rbyte;
                        issue(eeprom_pkg::BIT_OP_STOP, '0);
                        state <= eeprom_pkg::SEQ_STOP;
                    end
                eeprom_pkg::SEQ_STOP:
                    if (bit_done)
                    begin
                        rsp_valid <= 1'b1;
                        state     <= eeprom_pkg::SEQ_IDLE;
                    end
                default: state <= eeprom_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            bit_go,
    input  logic [1:0]                      bit_op,
    input  logic [eeprom_pkg::DATA_W-1:0]   bit_wbyte,
    output logic                            bit_done,
    output logic [eeprom_pkg::DATA_W-1:0]   bit_rbyte,
    output logic                            bit_nack,
    output logic                            scl,
    output logic                            sda_pull_low,
    input  logic                            sda_in
);

    logic                            busy;
    logic                            tail;   // one cycle after the ack bit
    logic [1:0]                      op;
    logic [1:0]                      quarter;
    logic [1:0]                      next_quarter;
    logic [eeprom_pkg::QCNT_W-1:0]   qcnt;
    logic [3:0]                      bit_cnt;
    logic [3:0]                      next_bit;
    logic [eeprom_pkg::DATA_W-1:0]   shift;
    logic                            next_data;
    logic                            is_byte;
    logic                            tick;
    logic                            bit_end;
    logic                            last_bit;

    // {scl, pull_low} for one quarter of one bit
    function automatic logic [1:0] bus_level(
        input logic [1:0] f_op,
        input logic [1:0] f_q,
        input logic [3:0] f_bit,
        input logic       f_data
    );
        logic [1:0] lvl;
        case (f_op)
            eeprom_pkg::BIT_OP_START: lvl = {f_q == 2'd1 || f_q == 2'd2, f_q[1]};
            eeprom_pkg::BIT_OP_STOP:  lvl = {f_q != 2'd0, !f_q[1]};
            default:
                lvl = {f_q == 2'd1 || f_q == 2'd2,
                       f_op == eeprom_pkg::BIT_OP_WRBYTE && f_bit < 4'd8 && !f_data};
        endcase
        return lvl;
    endfunction

    assign is_byte  = op[1];   // WRBYTE and RDBYTE
    assign tick     = busy && !tail && (int'(qcnt) == eeprom_pkg::QUARTER_CYCLES - 1);
    assign bit_end  = tick && (quarter == 2'd3);
    assign last_bit = is_byte ? (bit_cnt == 4'd8) : 1'b1;
    assign bit_done = tail || (bit_end && !is_byte);
    assign bit_rbyte = shift;

    assign next_quarter = quarter + 2'd1;
    assign next_bit     = bit_end ? bit_cnt + 4'd1 : bit_cnt;
    assign next_data    = bit_end ? shift[6] : shift[7];   // shift moves on bit_end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy         <= 1'b0;
            tail         <= 1'b0;
            op           <= eeprom_pkg::BIT_OP_STOP;
            quarter      <= 2'd0;
            qcnt         <= '0;
            bit_cnt      <= 4'd0;
            scl          <= 1'b1;   // bus idle
            sda_pull_low <= 1'b0;
        end
        else if (bit_go && !busy)
        begin
            busy    <= 1'b1;
            op      <= bit_op;
            quarter <= 2'd0;
            qcnt    <= '0;
            bit_cnt <= 4'd0;
            {scl, sda_pull_low} <= bus_level(bit_op, 2'd0, 4'd0, bit_wbyte[7]);
        end
        else if (tail)
        begin
            tail <= 1'b0;
            busy <= 1'b0;
        end
        else if (busy)
        begin
            qcnt <= tick ? '0 : qcnt + 1'b1;
            if (bit_end && last_bit)
            begin
                if (is_byte)
                    tail <= 1'b1;
                else
                    busy <= 1'b0;
            end
            else if (tick)
            begin
                quarter <= next_quarter;
                bit_cnt <= next_bit;
                {scl, sda_pull_low} <= bus_level(op, next_quarter, next_bit, next_data);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bit_go && !busy)
        begin
            shift    <= bit_wbyte;
            bit_nack <= 1'b0;
        end
        else if (tick)
        begin
            if (quarter == 2'd1)   // scl high, sample
            begin
                if (op == eeprom_pkg::BIT_OP_RDBYTE && bit_cnt < 4'd8)
                    shift <= {shift[6:0], sda_in};
                if (op == eeprom_pkg::BIT_OP_WRBYTE && bit_cnt == 4'd8)
                    bit_nack <= sda_in;
            end
            if (bit_end && op == eeprom_pkg::BIT_OP_WRBYTE)
                shift <= {shift[6:0], 1'b0};
        end
    end

    // data bits only move while scl is low
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (busy && is_byte && scl && $past(scl)) |-> $stable(sda_pull_low))
        else $error("i2c_bit_engine: sda changed while scl high");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the eeprom controller testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_eeprom_ctrl -f src.f -o tb_eeprom_ctrl > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_eeprom_ctrl > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: src.f
eeprom_pkg.sv
cmd_queue.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

// File: tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;

    localparam int CLK_NS       = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RANDOM_PAIRS = 40;
    localparam int ALIAS_CMDS   = eeprom_pkg::ADDR_W - 8 + 1;
    localparam int NUM_CMDS     = 3 + ALIAS_CMDS + 2 * RANDOM_PAIRS
                                  + eeprom_pkg::CMD_DEPTH + 1 + 3;
    // 12 bus bytes of 72 cycles per command plus a margin
    localparam int WATCHDOG_NS  = NUM_CMDS * 12 * 72 * CLK_NS + 2000 * CLK_NS;

    logic                            CLK = 1'b0;
    logic                            RESET;
    logic                            cmd_valid;
    logic                            cmd_op;
    logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr;
    logic [eeprom_pkg::DATA_W-1:0]   cmd_wdata;
    logic                            cmd_credit;
    logic                            rsp_valid;
    logic [eeprom_pkg::DATA_W-1:0]   rsp_rdata;
    logic                            rsp_nack;
    logic                            scl;
    logic                            sda_pull_low;
    logic                            model_pull;
    logic                            sda_in;
    logic                            model_busy;

    logic [eeprom_pkg::DATA_W-1:0]   shadow [1 << eeprom_pkg::ADDR_W];
    logic [eeprom_pkg::DATA_W-1:0]   exp_rdata [$];
    logic                            exp_nack [$];
    logic                            exp_is_read [$];
    string                           exp_name [$];
    int cmds_sent      = 0;
    int credits_back   = 0;
    int rsp_count      = 0;
    int mismatch_count = 0;
    int other_errors   = 0;
    int final_errors   = 0;

    assign sda_in = !sda_pull_low && !model_pull;   // wired-AND line

    always #(CLK_NS / 2) CLK = ~CLK;

    eeprom_ctrl_top i_eeprom_ctrl_top (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_credit   (cmd_credit),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_nack     (rsp_nack),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

    tb_eeprom_model i_eeprom_model (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl          (scl),
        .sda          (sda_in),
        .busy         (model_busy),
        .sda_pull_low (model_pull)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int credits_held();
        return eeprom_pkg::CMD_DEPTH - cmds_sent + credits_back;
    endfunction

    // predicts {nack, rdata} and keeps the shadow array
    // a busy device acks nothing and keeps its data
    function automatic logic [eeprom_pkg::DATA_W:0] predict(
        input logic                          op,
        input logic [eeprom_pkg::ADDR_W-1:0] addr,
        input logic [eeprom_pkg::DATA_W-1:0] wdata
    );
        logic [eeprom_pkg::DATA_W:0] r;
        if (model_busy)
            r = {1'b1, 8'h00};
        else if (op == eeprom_pkg::OP_WRITE)
        begin
            shadow[addr] = wdata;
            r = {1'b0, 8'h00};
        end
        else
            r = {1'b0, shadow[addr]};
        return r;
    endfunction

    task automatic check_rdata(input string name,
                               input logic [eeprom_pkg::DATA_W-1:0] expected,
                               input logic [eeprom_pkg::DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s rsp_rdata: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_nack(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s rsp_nack: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // starts and ends at a rising edge plus the drive delay
    task automatic send_cmd(input string                         name,
                            input logic                          op,
                            input logic [eeprom_pkg::ADDR_W-1:0] addr,
                            input logic [eeprom_pkg::DATA_W-1:0] wdata);
        logic [eeprom_pkg::DATA_W:0] pred;
        while (credits_held() == 0)
        begin
            @(posedge CLK);
            #DRIVE_DELAY;
        end
        pred = predict(op, addr, wdata);
        exp_rdata.push_back(pred[eeprom_pkg::DATA_W-1:0]);
        exp_nack.push_back(pred[eeprom_pkg::DATA_W]);
        exp_is_read.push_back(op == eeprom_pkg::OP_READ);
        exp_name.push_back(name);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmds_sent++;
        @(posedge CLK);
        #DRIVE_DELAY;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (rsp_count < exp_nack.size())
        begin
            @(posedge CLK);
            #DRIVE_DELAY;
        end
    endtask

    // credits and responses are checked in command order
    always @(posedge CLK)
    begin
        if (!RESET && cmd_credit)
        begin
            if (credits_back >= cmds_sent)
            begin
                $display("credit returned while no command was outstanding");
                other_errors++;
            end
            credits_back++;
        end
        if (!RESET && rsp_valid)
        begin
            if (rsp_count >= exp_nack.size())
            begin
                $display("response arrived with no command waiting for it");
                other_errors++;
            end
            else
            begin
                check_nack(exp_name[rsp_count], exp_nack[rsp_count], rsp_nack);
                if (exp_is_read[rsp_count] && !exp_nack[rsp_count])
                    check_rdata(exp_name[rsp_count], exp_rdata[rsp_count], rsp_rdata);
                rsp_count++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d of %0d responses seen", rsp_count, cmds_sent);
        $display("test failed");
        $finish;
    end

    initial
    begin
        logic [31:0]                   rng;
        logic [eeprom_pkg::ADDR_W-1:0] addr_a;
        logic [eeprom_pkg::ADDR_W-1:0] addr_b;
        logic [eeprom_pkg::ADDR_W-1:0] rd_addr;
        int                            burst_base;
        RESET      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        model_busy = 1'b0;
        shadow     = '{default: 8'hff};
        rng        = 32'heaf8_8cdd;
        repeat (3) @(posedge CLK);
        #DRIVE_DELAY;
        RESET = 1'b0;
        @(posedge CLK);
        #DRIVE_DELAY;

        send_cmd("unwritten", eeprom_pkg::OP_READ, 11'h5a3, '0);
        wait_idle();

        rng    = lcg_next(rng);
        addr_a = rng[26:16];
        send_cmd("write_read", eeprom_pkg::OP_WRITE, addr_a, rng[7:0]);
        send_cmd("write_read", eeprom_pkg::OP_READ, addr_a, '0);
        wait_idle();

        // same low byte, each differs from addr_a in one select byte bit
        for (int b = 8; b < eeprom_pkg::ADDR_W; b++)
            send_cmd("alias", eeprom_pkg::OP_WRITE, addr_a ^ (11'd1 << b), ~shadow[addr_a]);
        send_cmd("alias", eeprom_pkg::OP_READ, addr_a, '0);
        wait_idle();

        // high address bits go out in the select byte
        for (int i = 0; i < RANDOM_PAIRS; i++)
        begin
            rng    = lcg_next(rng);
            addr_b = rng[26:16];
            rng    = lcg_next(rng);
            send_cmd("random", eeprom_pkg::OP_WRITE, addr_b, rng[23:16]);
            rng     = lcg_next(rng);
            rd_addr = rng[31] ? addr_b : rng[26:16];
            send_cmd("random", eeprom_pkg::OP_READ, rd_addr, '0);
        end
        wait_idle();

        burst_base = credits_back;
        for (int i = 0; i <= eeprom_pkg::CMD_DEPTH; i++)
        begin
            rng = lcg_next(rng);
            if (i[0] == 1'b0)
            begin
                addr_b = rng[26:16];
                send_cmd("burst", eeprom_pkg::OP_WRITE, addr_b, rng[7:0]);
            end
            else
                send_cmd("burst", eeprom_pkg::OP_READ, addr_b, '0);
        end
        if (credits_held() != 0)
        begin
            $display("credits not used up by the burst, %0d still held", credits_held());
            final_errors++;
        end
        wait_idle();
        if (credits_back - burst_base != eeprom_pkg::CMD_DEPTH + 1)
        begin
            $display("burst returned %0d credits for %0d commands",
                     credits_back - burst_base, eeprom_pkg::CMD_DEPTH + 1);
            final_errors++;
        end

        model_busy = 1'b1;
        send_cmd("busy", eeprom_pkg::OP_WRITE, addr_a, ~shadow[addr_a]);
        send_cmd("busy", eeprom_pkg::OP_READ, addr_a, '0);
        wait_idle();
        model_busy = 1'b0;
        send_cmd("after_busy", eeprom_pkg::OP_READ, addr_a, '0);
        wait_idle();

        if (credits_held() != eeprom_pkg::CMD_DEPTH)
        begin
            $display("host ends with %0d credits instead of %0d",
                     credits_held(), eeprom_pkg::CMD_DEPTH);
            final_errors++;
        end
        if (rsp_count != exp_nack.size())
        begin
            $display("%0d expected responses never arrived", exp_nack.size() - rsp_count);
            final_errors++;
        end
        $display("errors: %0d value mismatches, %0d protocol, %0d end of run",
                 mismatch_count, other_errors, final_errors);
        if (mismatch_count + other_errors + final_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic busy,          // write cycle in progress, select is refused
    output logic sda_pull_low
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_DEV   = 3'd1;
    localparam logic [2:0] ST_ADDR  = 3'd2;
    localparam logic [2:0] ST_WDATA = 3'd3;
    localparam logic [2:0] ST_RDATA = 3'd4;
    localparam logic [2:0] ST_WAIT  = 3'd5;   // byte done, waiting for stop

    logic [7:0] mem [2048];
    logic [2:0] state;
    logic [3:0] bit_cnt;
    logic [7:0] rx;
    logic [7:0] tx;
    logic [2:0] addr_hi;
    logic [7:0] addr_lo;
    logic [7:0] wr_data;
    logic       wr_pending;
    logic       ack_clk;
    logic       prev_scl;
    logic       prev_sda;

    initial mem = '{default: 8'hff};   // erased part

    // bus oversampled on CLK, edges found against the previous sample
    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (RESET)
        begin
            state        <= ST_IDLE;
            bit_cnt      <= 4'd0;
            wr_pending   <= 1'b0;
            ack_clk      <= 1'b0;
            addr_lo      <= 8'h00;
            sda_pull_low <= 1'b0;
        end
        else if (scl && prev_scl && prev_sda && !sda)   // start or repeated start
        begin
            state        <= ST_DEV;
            bit_cnt      <= 4'd0;
            ack_clk      <= 1'b0;
            sda_pull_low <= 1'b0;
        end
        else if (scl && prev_scl && !prev_sda && sda)   // stop
        begin
            if (wr_pending)
                mem[{addr_hi, addr_lo}] <= wr_data;
            wr_pending   <= 1'b0;
            state        <= ST_IDLE;
            sda_pull_low <= 1'b0;
        end
        else if (scl && !prev_scl && state != ST_IDLE && state != ST_WAIT)
        begin
            if (bit_cnt < 4'd8)
            begin
                rx      <= {rx[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else
            begin
                ack_clk <= 1'b1;   // ninth clock
                bit_cnt <= 4'd0;
            end
        end
        else if (!scl && prev_scl)
        begin
            if (ack_clk)
            begin
                ack_clk      <= 1'b0;
                sda_pull_low <= 1'b0;
                case (state)
                    ST_DEV:
                    begin
                        addr_hi <= rx[3:1];
                        if (rx[0])
                        begin
                            state        <= ST_RDATA;
                            sda_pull_low <= !mem[{rx[3:1], addr_lo}][7];
                            tx           <= {mem[{rx[3:1], addr_lo}][6:0], 1'b1};
                        end
                        else
                            state <= ST_ADDR;
                    end
                    ST_ADDR:
                    begin
                        addr_lo <= rx;
                        state   <= ST_WDATA;
                    end
                    ST_WDATA:
                    begin
                        wr_data    <= rx;
                        wr_pending <= 1'b1;
                        state      <= ST_WAIT;
                    end
                    default: state <= ST_WAIT;   // master nacked the read byte
                endcase
            end
            else if (bit_cnt == 4'd8 && state == ST_RDATA)
                sda_pull_low <= 1'b0;   // master sends the ack bit
            else if (bit_cnt == 4'd8)
            begin
                case (state)
                    ST_DEV:
                        if (rx[7:4] == 4'b1010 && !busy)
                            sda_pull_low <= 1'b1;
                        else
                            state <= ST_IDLE;
                    ST_ADDR, ST_WDATA: sda_pull_low <= 1'b1;
                    default: state <= ST_IDLE;
                endcase
            end
            else if (state == ST_RDATA)
            begin
                sda_pull_low <= !tx[7];
                tx           <= {tx[6:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire
